//--- src/vga_pkg.sv
package vga_pkg;

	// Source image and scaling
	localparam int SRC_COLS   = 80;
	localparam int SRC_ROWS   = 60;
	localparam int SCALE_LOG2 = 3;
	localparam int SCALE      = 1 << SCALE_LOG2;
	localparam int FB_WORDS   = SRC_COLS * SRC_ROWS;
	localparam int ADDR_W     = 13;
	localparam int COL_W      = $clog2(SRC_COLS);

	// 640x480 raster, counted in pixel periods and lines
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_BLANK  = H_FRONT + H_SYNC + H_BACK;
	localparam int H_TOTAL  = H_ACTIVE + H_BLANK;
	localparam int H_CNT_W  = $clog2(H_TOTAL);

	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_BLANK  = V_FRONT + V_SYNC + V_BACK;
	localparam int V_TOTAL  = V_ACTIVE + V_BLANK;
	localparam int V_CNT_W  = $clog2(V_TOTAL);

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Host write command
	typedef struct packed {
		logic              en;
		logic [ADDR_W-1:0] addr;
		rgb_t              data;
	} fb_write_t;

endpackage

//--- src/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer (
	input  logic                            clk,
	input  vga_pkg::fb_write_t              host_wr,
	input  logic [vga_pkg::ADDR_W-1:0]      rd_addr,
	output vga_pkg::rgb_t                   rd_data
);
	import vga_pkg::*;

	rgb_t mem [FB_WORDS];

	logic wr_hit;

	// Writes past the last word are dropped
	assign wr_hit = host_wr.en && (host_wr.addr < ADDR_W'(FB_WORDS));

	////////////////////
	// Host write port
	////////////////////

	always_ff @(posedge clk) begin
		if (wr_hit)
			mem[host_wr.addr] <= host_wr.data;
	end

	////////////////////
	// Scan read port
	////////////////////

	// Asynchronous read, the pane sees data in the same cycle
	assign rd_data = mem[rd_addr];

endmodule

//--- src/display_pane.sv
`timescale 1ns/1ns

module display_pane (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            run,
	output logic [vga_pkg::ADDR_W-1:0]      rd_addr,
	input  vga_pkg::rgb_t                   rd_data,
	input  logic                            full,
	input  logic                            empty,
	output logic                            wr_en,
	output vga_pkg::rgb_t                   wr_data
);
	import vga_pkg::*;

	typedef enum logic {
		LOAD = 1'b0,
		WAIT = 1'b1
	} state_t;

	state_t state, nxt_state;

	logic [SCALE_LOG2-1:0] h_rep;
	logic [SCALE_LOG2-1:0] v_rep;
	logic [COL_W-1:0]      col;
	logic [ADDR_W-1:0]     curr_addr;
	logic [ADDR_W-1:0]     row_start;
	logic [ADDR_W-1:0]     next_start;

	logic last_copy;
	logic row_end;
	logic blk_end;

	////////////////////
	// Burst control
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= WAIT;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		wr_en = 1'b0;
		case (state)
			LOAD: begin
				if (full)
					nxt_state = WAIT;
				else
					wr_en = run;
			end
			WAIT: begin
				// Refill starts as soon as the FIFO reads empty
				if (empty) begin
					nxt_state = LOAD;
					wr_en = run;
				end
			end
			default: nxt_state = WAIT;
		endcase
	end

	////////////////////
	// Scan counters
	////////////////////

	assign last_copy = (h_rep == SCALE_LOG2'(SCALE - 1));
	assign row_end   = last_copy && (col == COL_W'(SRC_COLS - 1));
	assign blk_end   = row_end && (v_rep == SCALE_LOG2'(SCALE - 1));

	// Wrap to the top after the last source row
	assign next_start = (row_start == ADDR_W'(FB_WORDS - SRC_COLS)) ? '0 : curr_addr + 1'b1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			h_rep     <= '0;
			v_rep     <= '0;
			col       <= '0;
			curr_addr <= '0;
			row_start <= '0;
		end else if (wr_en) begin
			h_rep <= h_rep + 1'b1;
			if (last_copy) begin
				if (row_end) begin
					col   <= '0;
					v_rep <= v_rep + 1'b1;
					if (blk_end) begin
						row_start <= next_start;
						curr_addr <= next_start;
					end else begin
						// Same source row again
						curr_addr <= row_start;
					end
				end else begin
					col       <= col + 1'b1;
					curr_addr <= curr_addr + 1'b1;
				end
			end
		end
	end

	assign rd_addr = curr_addr;
	assign wr_data = rd_data;

endmodule

//--- src/pixel_fifo.sv
`timescale 1ns/1ns

module pixel_fifo (
	input  logic          clk,
	input  logic          rst,
	input  logic          wr_en,
	input  vga_pkg::rgb_t wr_data,
	input  logic          rd_en,
	output vga_pkg::rgb_t rd_data,
	output logic          full,
	output logic          empty
);
	import vga_pkg::*;

	rgb_t mem [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic [FIFO_PTR_W:0]   count_nxt;
	logic                  do_wr;
	logic                  do_rd;

	// Requests against a full or empty FIFO are ignored
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_comb begin
		count_nxt = count;
		if (do_wr && !do_rd)
			count_nxt = count + 1'b1;
		else if (do_rd && !do_wr)
			count_nxt = count - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_nxt;
			full  <= (count_nxt == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
			empty <= (count_nxt == '0);
		end
	end

	// Show-ahead head word
	assign rd_data = mem[rd_ptr];

endmodule

//--- src/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
	input  logic          clk,
	input  logic          rst,
	input  logic          run,
	input  logic          empty,
	input  vga_pkg::rgb_t rd_data,
	output logic          rd_en,
	output logic          pix_strobe,
	output logic          hsync,
	output logic          vsync,
	output logic          de,
	output vga_pkg::rgb_t pixel,
	output logic          underflow
);
	import vga_pkg::*;

	logic               pix_en;
	logic               tick;
	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic               h_act;
	logic               v_act;
	logic               h_sync_on;
	logic               v_sync_on;

	// Pixel period is two clocks
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pix_en <= 1'b0;
		else
			pix_en <= run && !pix_en;
	end

	assign tick = run && pix_en;

	////////////////////
	// Raster counters
	////////////////////

	// Each count starts with its blanking interval, then the active part
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (tick) begin
			if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
				h_cnt <= '0;
				if (v_cnt == V_CNT_W'(V_TOTAL - 1))
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign h_act     = (h_cnt >= H_CNT_W'(H_BLANK));
	assign v_act     = (v_cnt >= V_CNT_W'(V_BLANK));
	assign h_sync_on = (h_cnt >= H_CNT_W'(H_FRONT)) && (h_cnt < H_CNT_W'(H_FRONT + H_SYNC));
	assign v_sync_on = (v_cnt >= V_CNT_W'(V_FRONT)) && (v_cnt < V_CNT_W'(V_FRONT + V_SYNC));

	// One pop per active pixel period
	assign rd_en = tick && h_act && v_act;

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pix_strobe <= 1'b0;
			hsync      <= 1'b1;
			vsync      <= 1'b1;
			de         <= 1'b0;
			underflow  <= 1'b0;
		end else begin
			pix_strobe <= tick;
			if (!run) begin
				de <= 1'b0;
			end else if (tick) begin
				de    <= h_act && v_act;
				hsync <= !h_sync_on;
				vsync <= !v_sync_on;
			end
			if (rd_en && empty)
				underflow <= 1'b1;
		end
	end

	// Black when nothing was popped
	always_ff @(posedge clk) begin
		if (tick)
			pixel <= (rd_en && !empty) ? rd_data : '0;
	end

endmodule

//--- src/scaled_display_top.sv
`timescale 1ns/1ns

module scaled_display_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               run,
	input  vga_pkg::fb_write_t host_wr,
	output logic               pix_strobe,
	output logic               hsync,
	output logic               vsync,
	output logic               de,
	output vga_pkg::rgb_t      pixel,
	output logic               underflow
);
	import vga_pkg::*;

	logic [ADDR_W-1:0] fb_rd_addr;
	rgb_t              fb_rd_data;
	logic              fifo_wr_en;
	rgb_t              fifo_wr_data;
	logic              fifo_rd_en;
	rgb_t              fifo_rd_data;
	logic              fifo_full;
	logic              fifo_empty;

	frame_buffer u_frame_buffer (
		.clk     (clk),
		.host_wr (host_wr),
		.rd_addr (fb_rd_addr),
		.rd_data (fb_rd_data)
	);

	display_pane u_display_pane (
		.clk     (clk),
		.rst     (rst),
		.run     (run),
		.rd_addr (fb_rd_addr),
		.rd_data (fb_rd_data),
		.full    (fifo_full),
		.empty   (fifo_empty),
		.wr_en   (fifo_wr_en),
		.wr_data (fifo_wr_data)
	);

	pixel_fifo u_pixel_fifo (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (fifo_wr_en),
		.wr_data (fifo_wr_data),
		.rd_en   (fifo_rd_en),
		.rd_data (fifo_rd_data),
		.full    (fifo_full),
		.empty   (fifo_empty)
	);

	vga_timing u_vga_timing (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.empty      (fifo_empty),
		.rd_data    (fifo_rd_data),
		.rd_en      (fifo_rd_en),
		.pix_strobe (pix_strobe),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.pixel      (pixel),
		.underflow  (underflow)
	);

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst
);
	localparam int HALF_PERIOD = 2;
	localparam int RST_CYCLES  = 16;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk = ~clk;
		end
	end

	// Rising edge on rst at 1 ns, released on a falling clock edge
	initial begin
		rst = 1'b0;
		#1;
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- testbench/display_checker.sv
`timescale 1ns/1ns

module display_checker (
	input  logic               clk,
	input  logic               run,
	input  vga_pkg::fb_write_t host_wr,
	input  logic               ovr_phase,
	input  logic               end_check,
	input  int                 ovr_lines,
	input  logic               pix_strobe,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               de,
	input  vga_pkg::rgb_t      pixel,
	input  logic               underflow,
	output int                 frames_done,
	output int                 blocks_seen,
	output int                 value_errors,
	output int                 other_errors,
	output logic               report_done
);
	import vga_pkg::*;

	localparam int MAX_PRINT = 20;

	rgb_t model     [FB_WORDS];
	logic ovr_flag  [FB_WORDS];
	int   ovr_hits  [FB_WORDS];
	rgb_t first_img [H_ACTIVE * V_ACTIVE];

	logic run_seen = 1'b0;
	logic end_req  = 1'b0;
	logic idle_de_seen;
	logic uf_seen;
	logic prev_de;
	logic prev_hs;
	logic prev_vs;
	int   x;
	int   y;
	int   frame;
	int   hs_len;
	int   hs_pulses;
	int   vs_len;

	// Mirror of the frame buffer, updated on the same edge as the DUT
	always @(posedge clk) begin
		if (run)
			run_seen <= 1'b1;
		end_req <= end_check;
		if (host_wr.en && host_wr.addr < ADDR_W'(FB_WORDS)) begin
			model[host_wr.addr]    <= host_wr.data;
			ovr_flag[host_wr.addr] <= ovr_phase;
		end
	end

	task automatic flag_count(input string name, input int expected, input int actual);
		value_errors++;
		if (value_errors <= MAX_PRINT)
			$display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
	endtask

	task automatic flag_pixel(input string name, input rgb_t expected);
		value_errors++;
		if (value_errors <= MAX_PRINT)
			$display("[ERROR] %s expected %h actual %h (frame %0d, x %0d, y %0d)",
				name, expected, pixel, frame, x, y);
	endtask

	task automatic close_frame();
		if (y != V_ACTIVE)
			flag_count("frame_lines", V_ACTIVE, y);
		// One hsync pulse per line
		if (hs_pulses != V_TOTAL)
			flag_count("hsync_pulses", V_TOTAL, hs_pulses);
		// A block counts only if all 64 copies matched
		for (int i = 0; i < FB_WORDS; i++) begin
			if (ovr_flag[i] && ovr_hits[i] == SCALE * SCALE)
				blocks_seen++;
			ovr_hits[i] = 0;
		end
		frames_done++;
	endtask

	////////////////////
	// Per pixel period
	////////////////////

	task automatic check_period();
		int   addr;
		int   pos;
		rgb_t expected;
		if (prev_vs && !vsync) begin
			if (frame > 0)
				close_frame();
			frame++;
			y = 0;
			hs_pulses = 0;
		end
		if (!vsync) begin
			vs_len++;
		end else if (!prev_vs) begin
			if (vs_len != V_SYNC * H_TOTAL)
				flag_count("vsync_width", V_SYNC * H_TOTAL, vs_len);
			vs_len = 0;
		end
		if (!hsync) begin
			hs_len++;
		end else if (!prev_hs) begin
			if (hs_len != H_SYNC)
				flag_count("hsync_width", H_SYNC, hs_len);
			hs_len = 0;
			hs_pulses++;
		end
		if (de) begin
			if (x < H_ACTIVE && y < V_ACTIVE) begin
				addr     = (y / SCALE) * SRC_COLS + x / SCALE;
				pos      = y * H_ACTIVE + x;
				expected = model[addr];
				if (pixel !== expected)
					flag_pixel("scaling", expected);
				else if (ovr_flag[addr])
					ovr_hits[addr]++;
				if (frame == 1)
					first_img[pos] = pixel;
				else if (frame == 2 && pixel !== first_img[pos])
					flag_pixel("frame_repeat", first_img[pos]);
			end
			x++;
		end else if (prev_de) begin
			if (x != H_ACTIVE)
				flag_count("line_width", H_ACTIVE, x);
			x = 0;
			y++;
		end
		prev_de = de;
		prev_hs = hsync;
		prev_vs = vsync;
	endtask

	task automatic final_checks();
		if (frames_done < 2) begin
			other_errors++;
			$display("Fewer than two complete frames were seen, the repeat check did not run");
		end
		if (blocks_seen != ovr_lines * frames_done)
			flag_count("override_blocks", ovr_lines * frames_done, blocks_seen);
	endtask

	initial begin
		frames_done  = 0;
		blocks_seen  = 0;
		value_errors = 0;
		other_errors = 0;
		report_done  = 1'b0;
		idle_de_seen = 1'b0;
		uf_seen      = 1'b0;
		prev_de      = 1'b0;
		prev_hs      = 1'b1;
		prev_vs      = 1'b1;
		x            = 0;
		y            = 0;
		frame        = 0;
		hs_len       = 0;
		hs_pulses    = 0;
		vs_len       = 0;
		for (int i = 0; i < FB_WORDS; i++)
			ovr_hits[i] = 0;
		// Outputs only move on rising edges, so sample in the middle
		forever begin
			@(negedge clk);
			if (!run_seen && de && !idle_de_seen) begin
				idle_de_seen = 1'b1;
				flag_count("de_idle", 0, 1);
			end
			if (underflow && !uf_seen) begin
				uf_seen = 1'b1;
				flag_count("underflow", 0, 1);
			end
			if (pix_strobe)
				check_period();
			if (end_req && !report_done) begin
				final_checks();
				report_done = 1'b1;
			end
		end
	end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ns

module tb_top;
	import vga_pkg::*;

	localparam string PATTERN_FILE = "testbench/display_patterns.txt";
	localparam int    FRAME_CLKS   = 2 * H_TOTAL * V_TOTAL;
	localparam int    MAX_OVR      = 64;

	logic      clk;
	logic      rst;
	logic      run;
	fb_write_t host_wr;
	logic      pix_strobe;
	logic      hsync;
	logic      vsync;
	logic      de;
	rgb_t      pixel;
	logic      underflow;

	logic ovr_phase;
	logic end_check;
	logic report_done;
	logic armed;
	int   ovr_lines;
	int   n_frames;
	int   watch_clks;
	int   frames_done;
	int   blocks_seen;
	int   value_errors;
	int   other_errors;
	int   seed;

	logic [ADDR_W-1:0] ovr_addr [MAX_OVR];
	rgb_t              ovr_data [MAX_OVR];

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	scaled_display_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.host_wr    (host_wr),
		.pix_strobe (pix_strobe),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.pixel      (pixel),
		.underflow  (underflow)
	);

	display_checker u_checker (
		.clk          (clk),
		.run          (run),
		.host_wr      (host_wr),
		.ovr_phase    (ovr_phase),
		.end_check    (end_check),
		.ovr_lines    (ovr_lines),
		.pix_strobe   (pix_strobe),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.pixel        (pixel),
		.underflow    (underflow),
		.frames_done  (frames_done),
		.blocks_seen  (blocks_seen),
		.value_errors (value_errors),
		.other_errors (other_errors),
		.report_done  (report_done)
	);

	// W lines give override writes, the N line gives the frame count
	task automatic read_patterns();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] a_val;
		logic [31:0] d_val;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file %s", PATTERN_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cnt = $fgets(line, fd);
				if (cnt > 0 && line.len() > 0 && line[0] == "W") begin
					cnt = $sscanf(line, "W %h %h", a_val, d_val);
					if (cnt == 2 && ovr_lines < MAX_OVR) begin
						ovr_addr[ovr_lines] = a_val[ADDR_W-1:0];
						ovr_data[ovr_lines] = d_val[23:0];
						ovr_lines++;
					end
				end else if (cnt > 0 && line.len() > 0 && line[0] == "N") begin
					cnt = $sscanf(line, "N %d", n_frames);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input rgb_t data, input logic ovr);
		@(negedge clk);
		host_wr.en   = 1'b1;
		host_wr.addr = addr;
		host_wr.data = data;
		ovr_phase    = ovr;
	endtask

	initial begin
		logic [31:0] rnd;
		run        = 1'b0;
		host_wr    = '0;
		ovr_phase  = 1'b0;
		end_check  = 1'b0;
		armed      = 1'b0;
		ovr_lines  = 0;
		n_frames   = 0;
		watch_clks = 0;
		seed       = 32'he993_3a6c;
		read_patterns();
		if (n_frames < 2) begin
			$display("The pattern file gave no usable frame count, at least two are needed");
			$display("*** FAILED ***");
			$finish;
		end else begin
			watch_clks = (n_frames + 1) * FRAME_CLKS + 16 + FB_WORDS + ovr_lines + 8;
			armed = 1'b1;
			@(negedge rst);
			// Random background, then the overrides on top
			for (int i = 0; i < FB_WORDS; i++) begin
				rnd = $random(seed);
				write_word(ADDR_W'(i), rnd[23:0], 1'b0);
			end
			for (int i = 0; i < ovr_lines; i++)
				write_word(ovr_addr[i], ovr_data[i], 1'b1);
			@(negedge clk);
			host_wr.en = 1'b0;
			ovr_phase  = 1'b0;
			@(negedge clk);
			run = 1'b1;
			wait (frames_done >= n_frames);
			@(negedge clk);
			end_check = 1'b1;
			wait (report_done);
			$display("Summary: %0d frames, %0d override blocks, %0d value errors, %0d other errors",
				frames_done, blocks_seen, value_errors, other_errors);
			if (value_errors + other_errors == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////
	// Watchdog
	////////////////////

	initial begin
		wait (armed);
		repeat (watch_clks) @(posedge clk);
		$display("The run timed out after %0d clock cycles before all frames were checked",
			watch_clks);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- testbench/display_patterns.txt
# Override writes: W <buffer address, hex> <colour rrggbb, hex>, each address once
# Frame count: N <frames to check, decimal>
# Address = row * 80 + column of the 80 by 60 source image
W 0000 ff0000
W 0001 00ff00
W 004f 0000ff
W 0050 ffff00
W 0051 00ffff
W 0123 ff00ff
W 0320 808080
W 0640 c0c0c0
W 07d0 123456
W 0960 abcdef
W 0988 ffffff
W 0989 010203
W 09d8 fedcba
W 0a00 7f7f00
W 0fa0 00407f
W 1194 a05010
W 1270 5a5a5a
W 12bf e0e0e1
N 3

//--- vlog.f
src/vga_pkg.sv
src/frame_buffer.sv
src/display_pane.sv
src/pixel_fifo.sv
src/vga_timing.sv
src/scaled_display_top.sv
testbench/tb_clock.sv
testbench/display_checker.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 --top-module tb_top -f vlog.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
